//--- src/ioPortPkg.sv
// Processor port bus types, port address map and status byte bit positions
package ioPortPkg;

	//////////////////////////////////////////////////
	// Bus types
	//////////////////////////////////////////////////

	typedef logic [7:0] portAddr_t; // PicoBlaze port_id
	typedef logic [7:0] portData_t; // One byte on out_port or in_port

	// Write side of the PicoBlaze port bus, 17 bits
	typedef struct packed {
		portAddr_t portId;      // Address of the current access
		portData_t outPort;     // Byte written by the processor
		logic      writeStrobe; // Qualifies outPort for one cycle
	} picoBus_t;

	//////////////////////////////////////////////////
	// Port addresses
	//////////////////////////////////////////////////

	// Must match the CONSTANT table of the PicoBlaze program
	localparam portAddr_t paOob         = 8'h08; // (o) out-of-bounds byte
	localparam portAddr_t paConnEst     = 8'h09; // (i) link status byte
	localparam portAddr_t paCursorCheck = 8'h0A; // (o) read address and cursor
	localparam portAddr_t paRamWAddr    = 8'h0B; // (o) write address, raises enable
	localparam portAddr_t paValidFlag   = 8'h0C; // (i) placement valid flag
	localparam portAddr_t paRamSelect   = 8'h13; // (o) us or them board
	localparam portAddr_t paRamWVal     = 8'h18; // (o) cell value to write
	localparam portAddr_t paDataRx      = 8'h19; // (i) byte from the XBee
	localparam portAddr_t paShipCheck1  = 8'h1A; // (o) extra "us" read addresses
	localparam portAddr_t paShipCheck2  = 8'h1B;
	localparam portAddr_t paShipCheck3  = 8'h1C;
	localparam portAddr_t paShipCheck4  = 8'h1D;
	localparam portAddr_t paDataTx      = 8'h1E; // (o) byte to the XBee
	localparam portAddr_t paDataRam     = 8'h1F; // (i) selected board read data

	//////////////////////////////////////////////////
	// Status byte at paConnEst
	//////////////////////////////////////////////////

	localparam int connBit    = 7; // Other board has answered
	localparam int rxReadyBit = 6; // Received byte waiting

endpackage

//--- src/boardPkg.sv
// Board cell types, RAM select values, board RAM port struct and validity constants
package boardPkg;

	//////////////////////////////////////////////////
	// Cell types
	//////////////////////////////////////////////////

	typedef logic [7:0] cellAddr_t; // Linear board cell index
	typedef logic [1:0] cellVal_t;  // Cell content, zero is an empty cell

	// Which board memory the processor is talking to
	typedef enum logic {
		usRam   = 1'b0, // Our ships
		themRam = 1'b1  // Our guesses at their ships
	} ramSel_t;

	//////////////////////////////////////////////////
	// Board RAM port, 19 bits
	//////////////////////////////////////////////////

	typedef struct packed {
		cellAddr_t readAddr;    // Combinational read in the memory
		cellAddr_t writeAddr;
		logic      writeEnable; // Level, held until a read command
		cellVal_t  writeValue;
	} ramPort_t;

	//////////////////////////////////////////////////
	// Placement check
	//////////////////////////////////////////////////

	// Out-of-bounds byte value that overrides any RAM result
	localparam logic [7:0] outOfBounds = 8'hFF;

	// Bytes returned at the valid flag port
	localparam logic [7:0] validFlag   = 8'h01;
	localparam logic [7:0] invalidFlag = 8'h00;

endpackage

//--- src/boardRamPort.sv
// Board RAM select register, us/them read and write channels, and display cursor
`timescale 1ns/10ps

module boardRamPort (
	input  logic                clk,
	input  logic                arstN,
	input  ioPortPkg::picoBus_t bus,
	output boardPkg::ramPort_t  usRam,   // Our ships
	output boardPkg::ramPort_t  themRam, // Our guesses
	output boardPkg::cellAddr_t cursor,
	output boardPkg::ramSel_t   ramSel
);

	// Byte on the bus seen as a cell address or a cell value
	boardPkg::cellAddr_t busAddr;
	boardPkg::cellVal_t  busVal;

	assign busAddr = bus.outPort;
	assign busVal  = bus.outPort[1:0]; // Upper bits ignored

	//////////////////////////////////////////////////
	// Strobed register writes
	//////////////////////////////////////////////////

	// Write value and write address must both be sent after the select,
	// the address last since it raises the enable
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ramSel  <= boardPkg::usRam;
			usRam   <= '0;
			themRam <= '0;
			cursor  <= '0;
		end else if (bus.writeStrobe) begin
			case (bus.portId)
				ioPortPkg::paRamSelect: begin
					ramSel <= boardPkg::ramSel_t'(bus.outPort[0]); // Bit 0 only
				end

				ioPortPkg::paRamWVal: begin
					if (ramSel == boardPkg::usRam)
						usRam.writeValue <= busVal;
					else
						themRam.writeValue <= busVal;
				end

				// Address lands and the selected enable goes high together
				ioPortPkg::paRamWAddr: begin
					if (ramSel == boardPkg::usRam) begin
						usRam.writeAddr   <= busAddr;
						usRam.writeEnable <= 1'b1;
					end else begin
						themRam.writeAddr   <= busAddr;
						themRam.writeEnable <= 1'b1;
					end
				end

				// Read command, so both boards stop writing
				ioPortPkg::paCursorCheck: begin
					usRam.writeEnable   <= 1'b0;
					themRam.writeEnable <= 1'b0;
					if (ramSel == boardPkg::usRam)
						usRam.readAddr <= busAddr;
					else
						themRam.readAddr <= busAddr;
					cursor <= busAddr; // Display follows the read address
				end

				// Extra cells of a ship being placed, always on our board
				ioPortPkg::paShipCheck1,
				ioPortPkg::paShipCheck2,
				ioPortPkg::paShipCheck3,
				ioPortPkg::paShipCheck4: begin
					usRam.writeEnable <= 1'b0;
					usRam.readAddr    <= busAddr; // Select is not looked at
				end

				default: ; // Not ours
			endcase
		end
	end

endmodule

//--- src/placementChecker.sv
// Out-of-bounds register, "us" read data accumulator and placement valid flag
`timescale 1ns/10ps

module placementChecker (
	input  logic                clk,
	input  logic                arstN,
	input  ioPortPkg::picoBus_t bus,
	input  boardPkg::cellVal_t  usReadData,
	output logic                valid
);

	ioPortPkg::portData_t oob;        // Written by the processor at paOob
	boardPkg::cellVal_t   occupied;   // OR of every cell read since last clear
	logic                 clrPending; // Valid flag was read last cycle

	//////////////////////////////////////////////////
	// Out-of-bounds byte
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			oob <= '0;
		else if (bus.writeStrobe && bus.portId == ioPortPkg::paOob)
			oob <= bus.outPort;
	end

	//////////////////////////////////////////////////
	// Accumulator
	//////////////////////////////////////////////////

	// Any non-empty cell of the ship being placed sticks here
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			clrPending <= 1'b0;
			occupied   <= '0;
		end else begin
			clrPending <= (bus.portId == ioPortPkg::paValidFlag); // Read, no strobe
			if (clrPending)
				occupied <= '0; // Result consumed, start over
			else
				occupied <= occupied | usReadData;
		end
	end

	// In bounds and every checked cell empty
	assign valid = (oob != boardPkg::outOfBounds) && (occupied == '0);

endmodule

//--- src/xbeeLink.sv
// XBee receive latch with sticky ready flag, transmit byte and held send flag
`timescale 1ns/10ps

module xbeeLink (
	input  logic                 clk,
	input  logic                 arstN,
	input  ioPortPkg::picoBus_t  bus,
	input  logic                 rxDataReady, // One-cycle pulse per byte
	input  ioPortPkg::portData_t rxDataIn,
	output logic                 rxHold,
	output ioPortPkg::portData_t rxData,
	output logic                 txDataSend,
	output ioPortPkg::portData_t txDataOut
);

	//////////////////////////////////////////////////
	// Receive side
	//////////////////////////////////////////////////

	// Byte and flag stay put until the processor reads paDataRx
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rxData <= '0;
			rxHold <= 1'b0;
		end else begin
			if (rxDataReady)
				rxData <= rxDataIn;
			if (rxDataReady)
				rxHold <= 1'b1; // New byte beats a read in the same cycle
			else if (bus.portId == ioPortPkg::paDataRx)
				rxHold <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Transmit side
	//////////////////////////////////////////////////

	// No busy feedback from the radio, so send stays up until the other board replies
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			txDataSend <= 1'b0;
			txDataOut  <= '0;
		end else begin
			if (bus.portId == ioPortPkg::paDataTx)
				txDataSend <= 1'b1;
			else if (rxDataReady)
				txDataSend <= 1'b0; // Reply seen
			if (bus.writeStrobe && bus.portId == ioPortPkg::paDataTx)
				txDataOut <= bus.outPort;
		end
	end

endmodule

//--- src/picoResponder.sv
// Registered PicoBlaze read multiplexer and closed-loop interrupt latch
`timescale 1ns/10ps

module picoResponder (
	input  logic                 clk,
	input  logic                 arstN,
	input  ioPortPkg::portAddr_t portId,
	input  logic                 connEstablished,
	input  logic                 rxHold,
	input  logic                 valid,
	input  ioPortPkg::portData_t rxData,
	input  boardPkg::ramSel_t    ramSel,
	input  boardPkg::cellVal_t   usReadData,
	input  boardPkg::cellVal_t   themReadData,
	input  logic                 intRequest,
	input  logic                 interruptAck,
	output ioPortPkg::portData_t inPort,
	output logic                 interrupt
);

	ioPortPkg::portData_t statusByte; // Link status at paConnEst
	ioPortPkg::portData_t validByte;
	boardPkg::cellVal_t   ramData;    // Read data of the selected board
	ioPortPkg::portData_t readByte;   // Next value of inPort

	//////////////////////////////////////////////////
	// Read multiplexer
	//////////////////////////////////////////////////

	always_comb begin
		statusByte = '0;
		statusByte[ioPortPkg::connBit]    = connEstablished;
		statusByte[ioPortPkg::rxReadyBit] = rxHold; // Other bits stay zero
	end

	assign validByte = valid ? boardPkg::validFlag : boardPkg::invalidFlag;
	assign ramData   = (ramSel == boardPkg::usRam) ? usReadData : themReadData;

	// Only true inputs read back, everything else is zero
	always_comb begin
		case (portId)
			ioPortPkg::paConnEst:   readByte = statusByte;
			ioPortPkg::paValidFlag: readByte = validByte;
			ioPortPkg::paDataRx:    readByte = rxData;
			ioPortPkg::paDataRam:   readByte = ioPortPkg::portData_t'(ramData); // Zero-extend
			default:                readByte = '0;
		endcase
	end

	// Processor samples in_port one cycle after it drives port_id
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			inPort <= '0;
		else
			inPort <= readByte;
	end

	//////////////////////////////////////////////////
	// Interrupt latch
	//////////////////////////////////////////////////

	// Held from request until the processor acknowledges
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			interrupt <= 1'b0;
		else if (interruptAck)
			interrupt <= 1'b0; // Ack wins over a new request
		else if (intRequest)
			interrupt <= 1'b1;
	end

endmodule

//--- src/boardIoBridge.sv
// Top level of the PicoBlaze I/O bridge, wiring RAM port, checker, XBee link and responder
`timescale 1ns/10ps

module boardIoBridge (
	input  logic                 clk,
	input  logic                 arstN,
	input  ioPortPkg::picoBus_t  bus,           // Processor write side
	output ioPortPkg::portData_t inPort,        // Registered read byte
	input  logic                 intRequest,
	input  logic                 interruptAck,
	input  logic                 connEstablished,
	input  logic                 rxDataReady,   // One-cycle pulse from the XBee side
	input  ioPortPkg::portData_t rxDataIn,
	input  boardPkg::cellVal_t   usReadData,
	input  boardPkg::cellVal_t   themReadData,
	output boardPkg::ramPort_t   usRam,
	output boardPkg::ramPort_t   themRam,
	output boardPkg::cellAddr_t  cursor,        // To the display
	output logic                 interrupt,
	output logic                 txDataSend,
	output ioPortPkg::portData_t txDataOut
);

	boardPkg::ramSel_t    ramSel; // Current board for RAM reads
	logic                 valid;  // Placement check result
	logic                 rxHold; // Sticky receive-ready
	ioPortPkg::portData_t rxData; // Latched receive byte

	//////////////////////////////////////////////////
	// Write-side blocks
	//////////////////////////////////////////////////

	boardRamPort ramPortInst (
		.clk    (clk),
		.arstN  (arstN),
		.bus    (bus),
		.usRam  (usRam),
		.themRam(themRam),
		.cursor (cursor),
		.ramSel (ramSel)
	);

	placementChecker checkerInst (
		.clk       (clk),
		.arstN     (arstN),
		.bus       (bus),
		.usReadData(usReadData),
		.valid     (valid)
	);

	xbeeLink xbeeInst (
		.clk        (clk),
		.arstN      (arstN),
		.bus        (bus),
		.rxDataReady(rxDataReady),
		.rxDataIn   (rxDataIn),
		.rxHold     (rxHold),
		.rxData     (rxData),
		.txDataSend (txDataSend),
		.txDataOut  (txDataOut)
	);

	//////////////////////////////////////////////////
	// Read side and interrupt
	//////////////////////////////////////////////////

	picoResponder responderInst (
		.clk            (clk),
		.arstN          (arstN),
		.portId         (bus.portId),   // Reads need no strobe
		.connEstablished(connEstablished),
		.rxHold         (rxHold),
		.valid          (valid),
		.rxData         (rxData),
		.ramSel         (ramSel),
		.usReadData     (usReadData),
		.themReadData   (themReadData),
		.intRequest     (intRequest),
		.interruptAck   (interruptAck),
		.inPort         (inPort),
		.interrupt      (interrupt)
	);

endmodule

//--- tests/boardRamModel.sv
// Behavioral "us" and "them" board memories with write on enable and combinational read
`timescale 1ns/10ps

module boardRamModel (
	input  logic               clk,
	input  boardPkg::ramPort_t usRam,
	input  boardPkg::ramPort_t themRam,
	output boardPkg::cellVal_t usReadData,
	output boardPkg::cellVal_t themReadData
);

	boardPkg::cellVal_t usMem   [256]; // Our ships
	boardPkg::cellVal_t themMem [256]; // Our guesses

	// Both boards start out empty
	initial begin
		for (int i = 0; i < 256; i++) begin
			usMem[i]   = '0;
			themMem[i] = '0;
		end
	end

	// Level enable, so a held enable keeps rewriting the same cell
	always @(posedge clk) begin
		if (usRam.writeEnable)
			usMem[usRam.writeAddr] <= usRam.writeValue;
		if (themRam.writeEnable)
			themMem[themRam.writeAddr] <= themRam.writeValue;
	end

	assign usReadData   = usMem[usRam.readAddr];     // No read latency
	assign themReadData = themMem[themRam.readAddr];

endmodule

//--- tests/boardIoBridgeTb.sv
// Testbench for the I/O bridge with clock, reset, port access tasks and checks per behavior
`timescale 1ns/10ps

module boardIoBridgeTb;

	localparam int waitLimit    = 16; // Cycles before a wait gives up
	localparam int sigInterrupt = 0;  // Selectors for waitForLevel
	localparam int sigTxSend    = 1;
	localparam int sigUsWe      = 2;
	localparam int sigThemWe    = 3;

	logic                 clk = 1'b0;
	logic                 arstN;
	ioPortPkg::picoBus_t  bus;
	ioPortPkg::portData_t inPort;
	logic                 intRequest, interruptAck, connEstablished, rxDataReady;
	ioPortPkg::portData_t rxDataIn, txDataOut;
	boardPkg::cellVal_t   usReadData, themReadData;
	boardPkg::ramPort_t   usRam, themRam;
	boardPkg::cellAddr_t  cursor;
	logic                 interrupt, txDataSend;
	integer               seed;
	int                   valueErrors = 0;
	int                   timeoutErrors = 0;

	boardIoBridge boardIoBridge_inst (
		.clk(clk), .arstN(arstN), .bus(bus), .inPort(inPort),
		.intRequest(intRequest), .interruptAck(interruptAck),
		.connEstablished(connEstablished), .rxDataReady(rxDataReady), .rxDataIn(rxDataIn),
		.usReadData(usReadData), .themReadData(themReadData),
		.usRam(usRam), .themRam(themRam), .cursor(cursor),
		.interrupt(interrupt), .txDataSend(txDataSend), .txDataOut(txDataOut)
	);

	// Closes the RAM loop
	boardRamModel ramModel (
		.clk(clk), .usRam(usRam), .themRam(themRam),
		.usReadData(usReadData), .themReadData(themReadData)
	);

	always #50 clk = ~clk; // 100 ns period

	//////////////////////////////////////////////////
	// Helpers entered and left on a falling edge
	//////////////////////////////////////////////////

	task automatic expectByte(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		assert (actual === expected) else begin
			valueErrors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic logic levelOf(input int which);
		case (which)
			sigInterrupt: return interrupt;
			sigTxSend:    return txDataSend;
			sigUsWe:      return usRam.writeEnable;
			default:      return themRam.writeEnable;
		endcase
	endfunction

	task automatic waitForLevel(input int which, input logic level, input string what);
		int n;
		n = 0;
		while (levelOf(which) !== level && n < waitLimit) begin
			@(negedge clk);
			n++;
		end
		assert (levelOf(which) === level) else begin
			timeoutErrors++;
			$display("Timeout: %s did not go to %b within %0d cycles", what, level, waitLimit);
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Strobed write captured on the rising edge in between
	task automatic writePort(input ioPortPkg::portAddr_t addr, input ioPortPkg::portData_t data);
		bus.portId      = addr;
		bus.outPort     = data;
		bus.writeStrobe = 1'b1;
		@(negedge clk);
		bus = '0; // Port 0x00 is unused
	endtask

	// Read access with inPort registered one cycle later
	task automatic readPort(input ioPortPkg::portAddr_t addr, output ioPortPkg::portData_t data);
		bus.portId      = addr;
		bus.outPort     = '0;
		bus.writeStrobe = 1'b0;
		@(negedge clk);
		data = inPort;
		bus  = '0;
	endtask

	task automatic readExpect(input string name, input ioPortPkg::portAddr_t addr,
			input ioPortPkg::portData_t expected);
		ioPortPkg::portData_t data;
		readPort(addr, data);
		expectByte(name, expected, data);
	endtask

	// Value, address, then a cursor check to drop the enable
	task automatic writeCell(input boardPkg::cellAddr_t addr, input boardPkg::cellVal_t val);
		writePort(ioPortPkg::paRamWVal, {6'b0, val});
		writePort(ioPortPkg::paRamWAddr, addr);
		writePort(ioPortPkg::paCursorCheck, addr);
	endtask

	task automatic pulseRx(input ioPortPkg::portData_t data);
		rxDataIn    = data;
		rxDataReady = 1'b1;
		@(negedge clk);
		rxDataReady = 1'b0;
		rxDataIn    = ~data; // Must not be captured without the pulse
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		boardPkg::cellVal_t   val;
		boardPkg::cellAddr_t  addr, themAddr;
		boardPkg::ramPort_t   selPort, otherPort;
		ioPortPkg::portData_t rd, rxByte, txByte;
		seed = 88;
		arstN = 1'b0;
		bus = '0;
		intRequest = 1'b0;
		interruptAck = 1'b0;
		connEstablished = 1'b0;
		rxDataReady = 1'b0;
		rxDataIn = '0;
		repeat (2) @(posedge clk); // Two edges under reset
		@(negedge clk);
		arstN = 1'b1;

		// Reset state
		expectByte("reset interrupt", 8'h00, {7'b0, interrupt});
		expectByte("reset txDataSend", 8'h00, {7'b0, txDataSend});
		expectByte("reset us writeEnable", 8'h00, {7'b0, usRam.writeEnable});
		expectByte("reset them writeEnable", 8'h00, {7'b0, themRam.writeEnable});
		readExpect("reset status byte", ioPortPkg::paConnEst, 8'h00);

		// RAM routing on the us board and then the them board
		for (int s = 0; s < 2; s++) begin
			val = boardPkg::cellVal_t'($random(seed));
			if (val == '0)
				val = 2'd3; // Nonzero so the read-back is distinctive
			addr = boardPkg::cellAddr_t'($random(seed));
			writePort(ioPortPkg::paRamSelect, ioPortPkg::portData_t'(s));
			writePort(ioPortPkg::paRamWVal, {6'b0, val});
			writePort(ioPortPkg::paRamWAddr, addr);
			waitForLevel((s == 0) ? sigUsWe : sigThemWe, 1'b1, "selected writeEnable");
			selPort   = (s == 0) ? usRam : themRam;
			otherPort = (s == 0) ? themRam : usRam;
			expectByte("route other writeEnable", 8'h00, {7'b0, otherPort.writeEnable});
			expectByte("route writeAddr", addr, selPort.writeAddr);
			expectByte("route writeValue", {6'b0, val}, {6'b0, selPort.writeValue});
			writePort(ioPortPkg::paCursorCheck, addr);
			expectByte("cursor check us writeEnable", 8'h00, {7'b0, usRam.writeEnable});
			expectByte("cursor check them writeEnable", 8'h00, {7'b0, themRam.writeEnable});
			expectByte("cursor check cursor", addr, cursor);
			readExpect("RAM read-back", ioPortPkg::paDataRam, {6'b0, val});
		end

		// Ship-check ports load the us read address only
		themAddr = addr; // Last cursor check went to the them board
		writePort(ioPortPkg::paRamSelect, 8'h01);
		for (int i = 0; i < 4; i++) begin
			addr = boardPkg::cellAddr_t'($random(seed));
			writePort(ioPortPkg::portAddr_t'(ioPortPkg::paShipCheck1 + i), addr);
			expectByte("ship check us readAddr", addr, usRam.readAddr);
			expectByte("ship check them readAddr", themAddr, themRam.readAddr);
			expectByte("ship check cursor", themAddr, cursor);
		end

		//////////////////////////////////////////////////
		// Validity
		//////////////////////////////////////////////////

		writePort(ioPortPkg::paRamSelect, 8'h00);
		writeCell(8'h21, 2'd2); // Occupied
		writeCell(8'h22, 2'd0);
		writeCell(8'h23, 2'd0); // Read address ends on an empty cell
		writePort(ioPortPkg::paShipCheck1, 8'h22);
		writePort(ioPortPkg::paOob, 8'h05);
		readPort(ioPortPkg::paValidFlag, rd); // Clears the accumulator
		idleCycles(1);                        // Clear lands here
		readExpect("valid empty cells", ioPortPkg::paValidFlag, boardPkg::validFlag);
		writePort(ioPortPkg::paShipCheck1, 8'h21);
		idleCycles(1); // Occupied cell gets ORed in
		readExpect("invalid occupied cell", ioPortPkg::paValidFlag, boardPkg::invalidFlag);
		writePort(ioPortPkg::paShipCheck1, 8'h22);
		readPort(ioPortPkg::paValidFlag, rd);
		idleCycles(1);
		writePort(ioPortPkg::paOob, boardPkg::outOfBounds);
		readExpect("invalid out of bounds", ioPortPkg::paValidFlag, boardPkg::invalidFlag);

		// XBee receive side with status bits 7 and 6
		connEstablished = 1'b1;
		rxByte = ioPortPkg::portData_t'($random(seed));
		pulseRx(rxByte);
		readExpect("rx ready status", ioPortPkg::paConnEst, 8'hC0);
		readExpect("rx ready still held", ioPortPkg::paConnEst, 8'hC0);
		readExpect("rx data", ioPortPkg::paDataRx, rxByte);
		readExpect("rx ready cleared", ioPortPkg::paConnEst, 8'h80);

		// XBee transmit side
		txByte = ioPortPkg::portData_t'($random(seed));
		writePort(ioPortPkg::paDataTx, txByte);
		waitForLevel(sigTxSend, 1'b1, "txDataSend after paDataTx");
		expectByte("tx data", txByte, txDataOut);
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			expectByte("tx send held", 8'h01, {7'b0, txDataSend});
		end
		pulseRx(8'h00); // Other board answers
		expectByte("tx send dropped", 8'h00, {7'b0, txDataSend});
		readPort(ioPortPkg::paDataRx, rd);

		// Interrupt latch
		intRequest = 1'b1;
		waitForLevel(sigInterrupt, 1'b1, "interrupt after intRequest");
		intRequest = 1'b0;
		idleCycles(3);
		expectByte("interrupt held", 8'h01, {7'b0, interrupt});
		interruptAck = 1'b1;
		waitForLevel(sigInterrupt, 1'b0, "interrupt after interruptAck");
		interruptAck = 1'b0;
		intRequest = 1'b1;
		waitForLevel(sigInterrupt, 1'b1, "interrupt set again");
		interruptAck = 1'b1; // Request and ack together
		@(negedge clk);
		intRequest = 1'b0;
		interruptAck = 1'b0;
		expectByte("interrupt ack wins", 8'h00, {7'b0, interrupt});

		$display("Errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
		if (valueErrors + timeoutErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- sim.f
src/ioPortPkg.sv
src/boardPkg.sv
src/boardRamPort.sv
src/placementChecker.sv
src/xbeeLink.sv
src/picoResponder.sv
src/boardIoBridge.sv
tests/boardRamModel.sv
tests/boardIoBridgeTb.sv
